// File: all.f
+incdir+hw
+incdir+sim
hw/wb_bus_pkg.sv
hw/pid_types_pkg.sv
hw/gain_bank.sv
hw/wb_arbiter.sv
hw/pid_axis.sv
hw/rate_ctrl_top.sv
sim/tb_rate_ctrl.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_rate_ctrl
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_pid_model.svh
/*
 * PID reference model for the rate-control testbench
 * per-axis gains, integrator and previous error in 64-bit arithmetic
 */
`ifndef TB_PID_MODEL_SVH
`define TB_PID_MODEL_SVH

longint model_gain [0:`N_AXES-1][0:2];   // kp, ki, kd as last written by the host
longint model_integ [0:`N_AXES-1];
longint model_prev [0:`N_AXES-1];

function automatic longint clamp(input longint v, input int bits);
	longint lim;
	lim = longint'(1) <<< (bits - 1);
	if (v >= lim)
		return lim - 1;
	if (v < -lim)
		return -lim;
	return v;
endfunction

// one axis run: error, saturating integrator, derivative, scaled and clamped sum
task automatic model_step(input int ax, input axis_in_t c, output logic [`RATE_W-1:0] rate);
	longint err;
	longint deriv;
	longint sum;
	err = longint'($signed(c.target)) - longint'($signed(c.actual));
	model_integ[ax] = clamp(model_integ[ax] + err, `INTEG_W);
	deriv = err - model_prev[ax];
	model_prev[ax] = err;
	sum = model_gain[ax][KP] * err + model_gain[ax][KI] * model_integ[ax]
		+ model_gain[ax][KD] * deriv;
	rate = `RATE_W'(clamp(sum >>> `GAIN_SHIFT, `RATE_W));
endtask

`endif

// File: sim/tb_rate_ctrl.sv
/*
 * testbench for the rate-control core
 * host gain load, single and concurrent axis runs, saturation and the
 * complete handshake, all checked against a PID model
 */
`default_nettype none
`include "rate_ctrl_config.svh"

module tb_rate_ctrl
	import wb_bus_pkg::*, pid_types_pkg::*;
();

	// host accesses and axis runs of the whole sequence
	localparam int N_OPS     = 24 + 33 + 29 + 434 + 8 + 46;
	localparam int RUN_LIMIT = 200;

	logic               us_clk;
	logic               resetn;
	wb_req_t            host_req;
	wb_rsp_t            host_rsp;
	axis_in_t           axis_cmd [0:`N_AXES-1];
	logic [`N_AXES-1:0] start;
	logic [`N_AXES-1:0] wait_ack;
	axis_out_t          axis_res [0:`N_AXES-1];
	logic [31:0]        lcg_state = 32'h7ad4;
	int                 errors = 0;
	int                 timeouts = 0;

	`include "tb_pid_model.svh"

	rate_ctrl_top i_dut (.*);

	initial begin
		us_clk = 1'b0;
		forever #2 us_clk = ~us_clk;
	end

	initial begin
		repeat (N_OPS * RUN_LIMIT) @(posedge us_clk);
		$display("watchdog expired, the test sequence did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [`GAIN_W-1:0] modest_gain();
		logic [31:0] r;
		r = next_rand();
		return {{9{r[22]}}, r[22:16]};   // about +-64
	endfunction

	function automatic logic all_complete(input logic [2:0] mask);
		for (int a = 0; a < `N_AXES; a++)
			if (mask[a] && !axis_res[a].complete)
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic step();
		@(posedge us_clk);
		#1;   // inputs change just after the edge
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR %s expected %0h actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	// one classic cycle, cyc dropped in the cycle after ack, then an idle cycle
	task automatic host_access(input logic we, input logic [3:0] adr,
		input logic [`WB_DAT_W-1:0] wdat, output logic [`WB_DAT_W-1:0] rdat);
		int n;
		host_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdat};
		n = 0;
		do begin
			step();
			n++;
		end while (!host_rsp.ack && n < RUN_LIMIT);
		if (!host_rsp.ack) begin
			$display("host access to address %0d never got an ack", adr);
			timeouts++;
		end
		rdat = host_rsp.dat_r;
		step();   // ack is sampled at this edge
		host_req = '0;
		step();
		if (we && adr[1:0] != 2'd3)
			model_gain[adr[3:2]][adr[1:0]] = longint'($signed(wdat));
	endtask

	task automatic host_read(input logic [3:0] adr, input string name);
		logic [`WB_DAT_W-1:0] rdat;
		logic [`WB_DAT_W-1:0] expected;
		expected = (adr[1:0] == 2'd3) ? '0 : `WB_DAT_W'(model_gain[adr[3:2]][adr[1:0]]);
		host_access(1'b0, adr, '0, rdat);
		check(name, expected, rdat);
	endtask

	task automatic load_gains(input int ax, input logic [`GAIN_W-1:0] kp, ki, kd);
		logic [`WB_DAT_W-1:0] unused;
		host_access(1'b1, {2'(ax), KP}, kp, unused);
		host_access(1'b1, {2'(ax), KI}, ki, unused);
		host_access(1'b1, {2'(ax), KD}, kd, unused);
	endtask

	task automatic random_cmds();
		logic [31:0] r;
		for (int a = 0; a < `N_AXES; a++) begin
			r = next_rand();
			axis_cmd[a] = '{target: {{2{r[31]}}, r[31:18]}, actual: {{2{r[15]}}, r[15:2]}};
		end
	endtask

	// start the masked axes together, hold complete, then acknowledge
	task automatic run_axes(input logic [2:0] mask, input int hold, input string name);
		logic [`RATE_W-1:0] expected [0:`N_AXES-1];
		int n;
		for (int a = 0; a < `N_AXES; a++)
			if (mask[a])
				model_step(a, axis_cmd[a], expected[a]);
		start = mask;
		step();
		start = '0;
		for (int a = 0; a < `N_AXES; a++)
			if (mask[a])
				check($sformatf("%s axis %0d active", name, a), 1, axis_res[a].active);
		n = 0;
		while (!all_complete(mask) && n < RUN_LIMIT) begin
			step();
			n++;
		end
		if (!all_complete(mask)) begin
			$display("%s: axes %b did not signal complete in time", name, mask);
			timeouts++;
			return;
		end
		for (int h = 0; h <= hold; h++) begin
			for (int a = 0; a < `N_AXES; a++)
				if (mask[a]) begin
					check($sformatf("%s axis %0d rate", name, a), expected[a],
						axis_res[a].rate);
					check($sformatf("%s axis %0d complete", name, a), 1,
						axis_res[a].complete);
					check($sformatf("%s axis %0d idle", name, a), 0, axis_res[a].active);
				end
			if (h < hold) begin
				random_cmds();
				start = (h == 0) ? mask : '0;   // must be ignored while complete
				step();
				start = '0;
			end
		end
		wait_ack = mask;
		step();
		wait_ack = '0;
		for (int a = 0; a < `N_AXES; a++)
			if (mask[a])
				check($sformatf("%s axis %0d release", name, a), 0, axis_res[a].complete);
	endtask

	// large errors to a limit, then ki of 1 with zero error puts the integrator on the rate
	task automatic saturate(input int ax, input logic down, input int runs);
		logic [31:0] r;
		logic [2:0]  mask;
		mask = 3'(1 << ax);
		r = next_rand();
		load_gains(ax, {2'b01, r[31:18]}, {2'b01, r[17:4]}, {2'b01, r[29:16]});
		repeat (runs) begin
			r = next_rand();
			axis_cmd[ax].target = down ? 16'h8000 + r[23:16] : 16'h7fff - r[23:16];
			axis_cmd[ax].actual = down ? 16'h7fff - r[31:24] : 16'h8000 + r[31:24];
			run_axes(mask, 0, "saturation");
		end
		load_gains(ax, 16'd0, 16'd1, 16'd0);
		axis_cmd[ax] = '{target: r[15:0], actual: r[15:0]};
		run_axes(mask, 0, "integrator limit");
	endtask

	initial begin
		logic [31:0]          r;
		logic [`WB_DAT_W-1:0] unused;
		resetn   = 1'b0;
		host_req = '0;
		start    = '0;
		wait_ack = '0;
		for (int a = 0; a < `N_AXES; a++)
			axis_cmd[a] = '0;
		repeat (4) @(posedge us_clk);
		#1;
		resetn = 1'b1;

		for (int a = 0; a < `N_AXES; a++) begin
			check("reset complete", 0, axis_res[a].complete);
			check("reset active", 0, axis_res[a].active);
			check("reset rate", 0, axis_res[a].rate);
		end
		for (int adr = 0; adr < 12; adr++) begin
			r = next_rand();
			host_access(1'b1, 4'(adr), r[31:16], unused);   // offset 3 writes are dropped
		end
		for (int adr = 0; adr < 12; adr++)
			host_read(4'(adr), "gain readback");

		load_gains(0, modest_gain(), modest_gain(), modest_gain());
		repeat (30) begin
			random_cmds();
			run_axes(3'b001, 0, "single axis");
		end

		for (int a = 0; a < `N_AXES; a++)
			load_gains(a, modest_gain(), modest_gain(), modest_gain());
		repeat (20) begin
			random_cmds();
			run_axes(3'b111, 0, "three axes");
		end

		saturate(2, 1'b0, 140);
		saturate(2, 1'b1, 280);   // from the upper limit down to the lower one

		repeat (8) begin
			random_cmds();
			r = next_rand();
			run_axes(3'b010, 1 + int'(r[31:28]), "held complete");
		end

		fork
			begin
				repeat (6) begin
					random_cmds();
					run_axes(3'b111, 0, "concurrent axes");
				end
			end
			begin
				repeat (40) begin
					r = next_rand();
					host_read(4'(r[31:28] % 12), "concurrent read");
				end
			end
		join

		$display("errors %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/rate_ctrl_top.sv
/*
 * rate_ctrl_top
 * rate-control core with three PID axes and a host port sharing the gain
 * bank through a round-robin wishbone arbiter
 */
`default_nettype none
`include "rate_ctrl_config.svh"

module rate_ctrl_top
	import wb_bus_pkg::*, pid_types_pkg::*;
(
	input  logic              us_clk,
	input  logic              resetn,
	input  wb_req_t           host_req,
	output wb_rsp_t           host_rsp,
	input  axis_in_t          axis_cmd [0:`N_AXES-1],
	input  logic [`N_AXES-1:0] start,
	input  logic [`N_AXES-1:0] wait_ack,
	output axis_out_t         axis_res [0:`N_AXES-1]
);

	wb_req_t m_req [0:`N_AXES];   // master 0 is the host
	wb_rsp_t m_rsp [0:`N_AXES];
	wb_req_t slv_req;
	wb_rsp_t slv_rsp;

	assign m_req[0] = host_req;
	assign host_rsp = m_rsp[0];

	for (genvar a = 0; a < `N_AXES; a++) begin : g_axis
		pid_axis i_axis (
			.us_clk   (us_clk),
			.resetn   (resetn),
			.axis_id  (2'(a)),
			.cmd      (axis_cmd[a]),
			.start    (start[a]),
			.wait_ack (wait_ack[a]),
			.res      (axis_res[a]),
			.bus_req  (m_req[a+1]),
			.bus_rsp  (m_rsp[a+1])
		);
	end

	wb_arbiter i_arb (
		.us_clk  (us_clk),
		.resetn  (resetn),
		.m_req   (m_req),
		.m_rsp   (m_rsp),
		.slv_req (slv_req),
		.slv_rsp (slv_rsp)
	);

	gain_bank i_gains (
		.us_clk (us_clk),
		.resetn (resetn),
		.req    (slv_req),
		.rsp    (slv_rsp)
	);

endmodule

`default_nettype wire

// File: hw/pid_axis.sv
/*
 * pid_axis
 * single-axis rate PID engine. fetches kp, ki and kd over wishbone, then forms
 * error, saturating integrator, derivative and a scaled, saturated rate
 */
`default_nettype none
`include "rate_ctrl_config.svh"

module pid_axis
	import wb_bus_pkg::*, pid_types_pkg::*;
(
	input  logic       us_clk,
	input  logic       resetn,
	input  logic [1:0] axis_id,
	input  axis_in_t   cmd,
	input  logic       start,
	input  logic       wait_ack,
	output axis_out_t  res,
	output wb_req_t    bus_req,
	input  wb_rsp_t    bus_rsp
);

	axis_state_t state;
	gain_sel_t   gain_idx;    // gain word being read
	logic        cyc_q;
	axis_in_t    cmd_q;       // command captured at start

	logic signed [`GAIN_W-1:0]  kp, ki, kd;
	logic signed [`RATE_W:0]    err_c, err_q, prev_err_q;
	logic signed [`RATE_W+1:0]  deriv_c, deriv_q;
	logic signed [`INTEG_W:0]   integ_sum;   // one guard bit for overflow detect
	logic signed [`INTEG_W-1:0] integ_q;
	logic signed [`ACC_W-1:0]   p_q, i_q, d_q, sum_c, scaled_c;
	logic signed [`RATE_W-1:0]  rate_q;

	function automatic logic signed [`INTEG_W-1:0] sat_integ(input logic signed [`INTEG_W:0] v);
		if (v[`INTEG_W] != v[`INTEG_W-1])
			return v[`INTEG_W] ? {1'b1, {(`INTEG_W-1){1'b0}}} : {1'b0, {(`INTEG_W-1){1'b1}}};
		return v[`INTEG_W-1:0];
	endfunction

	// in range when every bit above the rate sign bit matches it
	function automatic logic signed [`RATE_W-1:0] sat_rate(input logic signed [`ACC_W-1:0] v);
		if (&v[`ACC_W-1:`RATE_W-1] || ~|v[`ACC_W-1:`RATE_W-1])
			return v[`RATE_W-1:0];
		return v[`ACC_W-1] ? {1'b1, {(`RATE_W-1){1'b0}}} : {1'b0, {(`RATE_W-1){1'b1}}};
	endfunction

	assign err_c = $signed({cmd_q.target[`RATE_W-1], cmd_q.target})
		- $signed({cmd_q.actual[`RATE_W-1], cmd_q.actual});
	assign deriv_c   = err_c - prev_err_q;
	assign integ_sum = integ_q + err_c;
	assign sum_c     = p_q + i_q + d_q;
	assign scaled_c  = sum_c >>> `GAIN_SHIFT;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state      <= WAIT;
			gain_idx   <= KP;
			cyc_q      <= 1'b0;
			integ_q    <= '0;
			prev_err_q <= '0;
			rate_q     <= '0;
		end else begin
			case (state)
				WAIT: begin
					if (start) begin
						state    <= FETCH;
						gain_idx <= KP;
						cyc_q    <= 1'b1;   // first read starts right away
					end
				end
				FETCH: begin
					if (!cyc_q) begin
						cyc_q <= 1'b1;      // idle cycle after ack is over
					end else if (bus_rsp.ack) begin
						cyc_q <= 1'b0;
						case (gain_idx)
							KP:      gain_idx <= KI;
							KI:      gain_idx <= KD;
							default: state <= CALC1;
						endcase
					end
				end
				CALC1: begin
					integ_q <= sat_integ(integ_sum);
					state   <= CALC2;
				end
				CALC2: state <= CALC3;
				CALC3: begin
					rate_q     <= sat_rate(scaled_c);
					prev_err_q <= err_q;
					state      <= COMPLETE;
				end
				COMPLETE: begin
					if (wait_ack)
						state <= WAIT;
				end
				default: state <= WAIT;
			endcase
		end
	end

	// captured command, gains, error terms and products
	always_ff @(posedge us_clk) begin
		if (state == WAIT && start)
			cmd_q <= cmd;
		if (state == FETCH && cyc_q && bus_rsp.ack) begin
			case (gain_idx)
				KP:      kp <= bus_rsp.dat_r;
				KI:      ki <= bus_rsp.dat_r;
				default: kd <= bus_rsp.dat_r;
			endcase
		end
		if (state == CALC1) begin
			err_q   <= err_c;
			deriv_q <= deriv_c;
		end
		if (state == CALC2) begin
			p_q <= kp * err_q;
			i_q <= ki * integ_q;     // integrator already updated in CALC1
			d_q <= kd * deriv_q;
		end
	end

	assign res = '{
		rate:     rate_q,
		complete: (state == COMPLETE),
		active:   (state == FETCH) || (state == CALC1) || (state == CALC2)
	};

	// read-only master, gain address is axis * 4 + offset
	assign bus_req = '{
		cyc:   cyc_q,
		stb:   cyc_q,
		we:    1'b0,
		adr:   {axis_id, gain_idx},
		dat_w: '0
	};

endmodule

`default_nettype wire

// File: hw/wb_arbiter.sv
/*
 * wb_arbiter
 * round-robin arbiter putting the host and the axis masters onto one
 * wishbone classic slave, grant held for the whole cycle
 */
`default_nettype none
`include "rate_ctrl_config.svh"

module wb_arbiter
	import wb_bus_pkg::*;
(
	input  logic    us_clk,
	input  logic    resetn,
	input  wb_req_t m_req [0:`N_AXES],
	output wb_rsp_t m_rsp [0:`N_AXES],
	output wb_req_t slv_req,
	input  wb_rsp_t slv_rsp
);

	localparam int N_M = `N_AXES + 1;   // host plus one per axis

	logic [1:0] gnt_q;
	logic [1:0] last_q;   // last master served
	logic [1:0] pick;
	logic       busy_q;
	logic       found;

	// search starts just after the last served master
	always_comb begin
		int cand;
		found = 1'b0;
		pick  = last_q;
		for (int i = 1; i <= N_M; i++) begin
			cand = (int'(last_q) + i) % N_M;
			if (!found && m_req[cand].cyc) begin
				found = 1'b1;
				pick  = 2'(cand);
			end
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			busy_q <= 1'b0;
			gnt_q  <= '0;
			last_q <= 2'(N_M - 1);   // host goes first
		end else if (!busy_q) begin
			if (found) begin
				busy_q <= 1'b1;
				gnt_q  <= pick;
			end
		end else if (!m_req[gnt_q].cyc) begin
			busy_q <= 1'b0;             // master closed its cycle
			last_q <= gnt_q;
		end
	end

	assign slv_req = busy_q ? m_req[gnt_q] : '0;

	for (genvar m = 0; m < N_M; m++) begin : g_rsp
		assign m_rsp[m] = '{
			ack:   busy_q && (gnt_q == 2'(m)) && slv_rsp.ack,
			dat_r: slv_rsp.dat_r
		};
	end

endmodule

`default_nettype wire

// File: hw/gain_bank.sv
/*
 * gain_bank
 * wishbone classic slave with kp, ki, kd for each axis, registered ack
 */
`default_nettype none
`include "rate_ctrl_config.svh"

module gain_bank
	import wb_bus_pkg::*;
(
	input  logic    us_clk,
	input  logic    resetn,
	input  wb_req_t req,
	output wb_rsp_t rsp
);

	localparam int N_WORDS = `N_AXES * 3;

	logic [`WB_DAT_W-1:0] gain_mem [0:N_WORDS-1];   // signed gains, raw bits
	logic [`WB_DAT_W-1:0] dat_r_q;
	logic                 ack_q;
	logic                 access;
	logic                 word_ok;
	logic [3:0]           word_idx;

	assign access   = req.cyc && req.stb && !ack_q;
	// offset 3 and axes past the last one are holes
	assign word_ok  = (req.adr[1:0] != 2'd3) && (req.adr[3:2] < 2'(`N_AXES));
	assign word_idx = 4'(req.adr[3:2]) * 4'd3 + 4'(req.adr[1:0]);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			ack_q <= 1'b0;
			for (int i = 0; i < N_WORDS; i++)
				gain_mem[i] <= '0;
		end else begin
			ack_q <= access;
			if (access && req.we && word_ok)
				gain_mem[word_idx] <= req.dat_w;
		end
	end

	always_ff @(posedge us_clk) begin
		if (access)
			dat_r_q <= word_ok ? gain_mem[word_idx] : '0;
	end

	assign rsp = '{ack: ack_q, dat_r: dat_r_q};

endmodule

`default_nettype wire

// File: hw/pid_types_pkg.sv
/*
 * pid axis types
 * engine states, gain word offsets and the axis command and result bundles
 */
`default_nettype none
`include "rate_ctrl_config.svh"

package pid_types_pkg;

	typedef enum logic [2:0] {
		WAIT,
		FETCH,    // reading kp, ki, kd from the gain bank
		CALC1,
		CALC2,
		CALC3,
		COMPLETE
	} axis_state_t;

	// word offset inside an axis's four-word gain block
	typedef enum logic [1:0] {
		KP = 2'd0,
		KI = 2'd1,
		KD = 2'd2
	} gain_sel_t;

	typedef struct packed {
		logic [`RATE_W-1:0] target;
		logic [`RATE_W-1:0] actual;   // measured rate from the imu
	} axis_in_t;

	typedef struct packed {
		logic [`RATE_W-1:0] rate;     // signed rate command
		logic               complete;
		logic               active;
	} axis_out_t;

endpackage

`default_nettype wire

// File: hw/wb_bus_pkg.sv
/*
 * wishbone classic bus types
 * request and response bundles shared by masters, arbiter and slave
 */
`default_nettype none
`include "rate_ctrl_config.svh"

package wb_bus_pkg;

	// master to slave
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [`WB_ADR_W-1:0] adr;
		logic [`WB_DAT_W-1:0] dat_w;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic                 ack;
		logic [`WB_DAT_W-1:0] dat_r;
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: hw/rate_ctrl_config.svh
/*
 * rate control configuration
 * datapath widths, axis count, gain fixed-point shift and bus sizes
 */
`ifndef RATE_CTRL_CONFIG_SVH
`define RATE_CTRL_CONFIG_SVH

`define RATE_W     16 // rate and imu word
`define GAIN_W     16 // signed gain
`define INTEG_W    24 // saturating integrator
`define ACC_W      48 // sum of products
`define GAIN_SHIFT 8  // fixed-point position of the gains

`define N_AXES     3  // roll, pitch, yaw

`define WB_ADR_W   4
`define WB_DAT_W   16

`endif
